//--- cpuPatterns.txt
// Word count, then the program words, four per line
// Expected count, then one writeback per line as test number, register and value
27
// Test 1 setup and R-type ALU ops
2001000c 2002fffb 34030ff0 34040f0f
00222820 00413022 00643824 00644025
0041482a
// Test 2 addi sign-extends, andi and ori zero-extend
200b8000 304c8001 340d8000
// Test 3 sll and srl
00017100 00027f02
// Test 4 three stores then three loads
ac020008 ac2b000c ac060028
8c110008 8c120018 8c33001c
// Test 5 taken beq, delay slots, two skipped words, untaken beq
12220005 20140001 00000000 00000000
20140063 20150063
10220005 20150002 20160003 20170004 20180005
// Test 6 write to r0 then read it
2000004d 00000000 00000000 20190007
// Halt, every branch targets the first one
1000ffff 1000fffe 1000fffd 1000fffc
1c
1 01 0000000c
1 02 fffffffb
1 03 00000ff0
1 04 00000f0f
1 05 00000007
1 06 ffffffef
1 07 00000f00
1 08 00000fff
1 09 00000001
2 0b ffff8000
2 0c 00008001
2 0d 00008000
3 0e 000000c0
3 0f 0000000f
4 11 fffffffb
4 12 ffff8000
4 13 ffffffef
5 14 00000001
5 00 00000000
5 00 00000000
5 15 00000002
5 16 00000003
5 17 00000004
5 18 00000005
6 00 0000004d
6 00 00000000
6 00 00000000
6 19 00000007

//--- cpuTop.sv
`timescale 1ns/1ns

module cpuTop
        import pipePkg::*;
#(
        parameter int imemDepth = 64,
        parameter int dmemDepth = 64
) (
        input  logic        clk,
        input  logic        rstN,
        input  progLoad     load,
        output logic [31:0] pc,
        output wbBus        wb
);

        // Stage to stage registers
        ifId  ifBus;
        idEx  idBus;
        exMem exBus;

        // Branch feedback from memory to fetch
        logic        branchTaken;
        logic [31:0] branchTarget;

        fetchStage #(.imemDepth(imemDepth)) uFetch (
                .clk          (clk),
                .rstN         (rstN),
                .load         (load),
                .branchTaken  (branchTaken),
                .branchTarget (branchTarget),
                .pc           (pc),
                .ifOut        (ifBus)
        );

        // Register file write comes back on wb
        decodeStage uDecode (
                .clk   (clk),
                .rstN  (rstN),
                .ifIn  (ifBus),
                .wb    (wb),
                .idOut (idBus)
        );

        executeStage uExecute (
                .clk   (clk),
                .rstN  (rstN),
                .exIn  (idBus),
                .exOut (exBus)
        );

        memoryStage #(.dmemDepth(dmemDepth)) uMemory (
                .clk          (clk),
                .rstN         (rstN),
                .memIn        (exBus),
                .branchTaken  (branchTaken),
                .branchTarget (branchTarget),
                .wb           (wb)
        );

endmodule

//--- decodeStage.sv
`timescale 1ns/1ns

module decodeStage
        import isaPkg::*, pipePkg::*;
(
        input  logic clk,
        input  logic rstN,
        input  ifId  ifIn,
        input  wbBus wb,
        output idEx  idOut
);

        // 32 x 32 register file, no reset
        logic [31:0] regs [32];

        instrWord    iw;
        logic        regWrite;
        logic        memToReg;
        logic        memWrite;
        logic        memRead;
        logic        branch;
        logic        aluSrc;
        logic        shiftOp;
        logic        regDst;
        logic        zeroExt;
        logic        knownOp;
        aluOp        alu;
        logic        rfWe;
        logic [31:0] rsData;
        logic [31:0] rtData;
        logic [31:0] imm;

        assign iw = ifIn.instr;

        ////////////////////////////////////////////////////////////////////////////
        // Main control
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                regWrite = 1'b0;
                memToReg = 1'b0;
                memWrite = 1'b0;
                memRead  = 1'b0;
                branch   = 1'b0;
                aluSrc   = 1'b0;
                shiftOp  = 1'b0;
                regDst   = 1'b0;
                zeroExt  = 1'b0;
                knownOp  = 1'b1;
                alu      = aluAdd;
                case (iw.rType.opcode)
                        opR: begin
                                regWrite = 1'b1;
                                regDst   = 1'b1;
                                // Second level decode on funct
                                case (iw.rType.funct)
                                        fnSub: alu = aluSub;
                                        fnAnd: alu = aluAnd;
                                        fnOr:  alu = aluOr;
                                        fnSlt: alu = aluSlt;
                                        fnSll: begin
                                                alu     = aluSll;
                                                shiftOp = 1'b1;
                                        end
                                        fnSrl: begin
                                                alu     = aluSrl;
                                                shiftOp = 1'b1;
                                        end
                                        default: alu = aluAdd;
                                endcase
                        end
                        opAddi: begin
                                regWrite = 1'b1;
                                aluSrc   = 1'b1;
                        end
                        opAndi: begin
                                regWrite = 1'b1;
                                aluSrc   = 1'b1;
                                zeroExt  = 1'b1;
                                alu      = aluAnd;
                        end
                        opOri: begin
                                regWrite = 1'b1;
                                aluSrc   = 1'b1;
                                zeroExt  = 1'b1;
                                alu      = aluOr;
                        end
                        opLw: begin
                                regWrite = 1'b1;
                                memRead  = 1'b1;
                                memToReg = 1'b1;
                                aluSrc   = 1'b1;
                        end
                        opSw: begin
                                memWrite = 1'b1;
                                aluSrc   = 1'b1;
                        end
                        opBeq: begin
                                branch = 1'b1;
                                alu    = aluSub;
                        end
                        default: knownOp = 1'b0;
                endcase
        end

        // Logic immediates zero-extend, the rest sign-extend
        assign imm = zeroExt ? {16'b0, iw.iType.imm16}
                             : {{16{iw.iType.imm16[15]}}, iw.iType.imm16};

        ////////////////////////////////////////////////////////////////////////////
        // Register file
        ////////////////////////////////////////////////////////////////////////////

        // Register zero never stored
        assign rfWe = wb.regWrite && (wb.writeReg != 5'd0);

        always_ff @(posedge clk) begin
                if (rfWe) begin
                        regs[wb.writeReg] <= wb.wbData;
                end
        end

        // Reads see a same-cycle writeback
        always_comb begin
                if (iw.iType.rs == 5'd0) begin
                        rsData = '0;
                end else if (rfWe && wb.writeReg == iw.iType.rs) begin
                        rsData = wb.wbData;
                end else begin
                        rsData = regs[iw.iType.rs];
                end
                if (iw.iType.rt == 5'd0) begin
                        rtData = '0;
                end else if (rfWe && wb.writeReg == iw.iType.rt) begin
                        rtData = wb.wbData;
                end else begin
                        rtData = regs[iw.iType.rt];
                end
        end

        // ID/EX register
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        idOut.valid <= 1'b0;
                end else begin
                        idOut.valid    <= ifIn.valid;
                        idOut.regWrite <= regWrite;
                        idOut.memToReg <= memToReg;
                        idOut.memWrite <= memWrite;
                        idOut.memRead  <= memRead;
                        idOut.branch   <= branch;
                        idOut.aluSrc   <= aluSrc;
                        idOut.shiftOp  <= shiftOp;
                        idOut.alu      <= alu;
                        idOut.rsData   <= rsData;
                        idOut.rtData   <= rtData;
                        idOut.imm      <= imm;
                        idOut.shamt    <= iw.rType.shamt;
                        idOut.pcPlus4  <= ifIn.pcPlus4;
                        idOut.writeReg <= regDst ? iw.rType.rd : iw.rType.rt;
                end
        end

        // Loaded program holds only supported opcodes
        opKnown: assert property (@(posedge clk) disable iff (!rstN)
                ifIn.valid |-> knownOp);

endmodule

//--- executeStage.sv
`timescale 1ns/1ns

module executeStage
        import isaPkg::*, pipePkg::*;
(
        input  logic clk,
        input  logic rstN,
        input  idEx  exIn,
        output exMem exOut
);

        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] aluResult;
        logic [31:0] branchTarget;
        logic        zero;

        ////////////////////////////////////////////////////////////////////////////
        // Operand select
        ////////////////////////////////////////////////////////////////////////////

        // Shifts take the amount on A, value from rt on B
        assign opA = exIn.shiftOp ? {27'b0, exIn.shamt} : exIn.rsData;
        // Immediate replaces rt for I-type arithmetic and addresses
        assign opB = exIn.aluSrc ? exIn.imm : exIn.rtData;

        ////////////////////////////////////////////////////////////////////////////
        // ALU
        ////////////////////////////////////////////////////////////////////////////

        always_comb begin
                case (exIn.alu)
                        aluAdd: aluResult = opA + opB;
                        aluSub: aluResult = opA - opB;
                        aluAnd: aluResult = opA & opB;
                        aluOr:  aluResult = opA | opB;
                        // Signed compare
                        aluSlt: aluResult = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
                        aluSll: aluResult = opB << opA[4:0];
                        // Logical, zero fill
                        aluSrl: aluResult = opB >> opA[4:0];
                        default: aluResult = '0;
                endcase
        end

        // beq compares via subtract
        assign zero = (aluResult == 32'd0);

        // Word offset relative to pc plus four
        assign branchTarget = exIn.pcPlus4 + {exIn.imm[29:0], 2'b00};

        // EX/MEM register
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        exOut.valid <= 1'b0;
                end else begin
                        exOut.valid        <= exIn.valid;
                        exOut.regWrite     <= exIn.regWrite;
                        exOut.memToReg     <= exIn.memToReg;
                        exOut.memWrite     <= exIn.memWrite;
                        exOut.memRead      <= exIn.memRead;
                        exOut.branch       <= exIn.branch;
                        exOut.zero         <= zero;
                        exOut.aluResult    <= aluResult;
                        // Store data is always rt
                        exOut.storeData    <= exIn.rtData;
                        exOut.branchTarget <= branchTarget;
                        exOut.writeReg     <= exIn.writeReg;
                end
        end

endmodule

//--- fetchStage.sv
`timescale 1ns/1ns

module fetchStage
        import pipePkg::*;
#(
        parameter int imemDepth = 64
) (
        input  logic        clk,
        input  logic        rstN,
        input  progLoad     load,
        input  logic        branchTaken,
        input  logic [31:0] branchTarget,
        output logic [31:0] pc,
        output ifId         ifOut
);

        localparam int imemAw = $clog2(imemDepth);

        // Instruction storage, written only by the load port
        logic [31:0] imem [imemDepth];

        logic [31:0]       pcPlus4;
        logic [imemAw-1:0] pcIdx;

        assign pcPlus4 = pc + 32'd4;
        // Word index from byte address
        assign pcIdx   = pc[imemAw+1:2];

        always_ff @(posedge clk) begin
                if (load.en) begin
                        imem[load.addr[imemAw-1:0]] <= load.data;
                end
        end

        // PC frozen at zero during load
        // Taken branch wins over sequential fetch
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        pc <= '0;
                end else if (load.en) begin
                        pc <= '0;
                end else if (branchTaken) begin
                        pc <= branchTarget;
                end else begin
                        pc <= pcPlus4;
                end
        end

        // IF/ID register, bubble while loading
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        ifOut.valid <= 1'b0;
                end else begin
                        ifOut.valid   <= !load.en;
                        ifOut.pcPlus4 <= pcPlus4;
                        ifOut.instr   <= imem[pcIdx];
                end
        end

        // Branch targets from the memory stage keep word alignment
        pcAligned: assert property (@(posedge clk) disable iff (!rstN)
                pc[1:0] == 2'b00);

endmodule

//--- isaPkg.sv
package isaPkg;

        ////////////////////////////////////////////////////////////////////////////
        // Instruction word layouts
        ////////////////////////////////////////////////////////////////////////////

        // R-type fields, MSB first
        typedef struct packed {
                logic [5:0] opcode;
                logic [4:0] rs;
                logic [4:0] rt;
                logic [4:0] rd;
                logic [4:0] shamt;
                logic [5:0] funct;
        } rFields;

        // I-type fields, MSB first
        typedef struct packed {
                logic [5:0]  opcode;
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [15:0] imm16;
        } iFields;

        // Same 32-bit word, two decodings
        typedef union packed {
                rFields rType;
                iFields iType;
        } instrWord;

        ////////////////////////////////////////////////////////////////////////////
        // Opcode and funct values
        ////////////////////////////////////////////////////////////////////////////

        localparam logic [5:0] opR    = 6'h00;
        localparam logic [5:0] opBeq  = 6'h04;
        localparam logic [5:0] opAddi = 6'h08;
        localparam logic [5:0] opAndi = 6'h0c;
        localparam logic [5:0] opOri  = 6'h0d;
        localparam logic [5:0] opLw   = 6'h23;
        localparam logic [5:0] opSw   = 6'h2b;

        // R-type funct field
        localparam logic [5:0] fnSll = 6'h00;
        localparam logic [5:0] fnSrl = 6'h02;
        localparam logic [5:0] fnAdd = 6'h20;
        localparam logic [5:0] fnSub = 6'h22;
        localparam logic [5:0] fnAnd = 6'h24;
        localparam logic [5:0] fnOr  = 6'h25;
        localparam logic [5:0] fnSlt = 6'h2a;

        // ALU operation, chosen in decode
        typedef enum logic [3:0] {
                aluAdd,
                aluSub,
                aluAnd,
                aluOr,
                aluSlt,
                aluSll,
                aluSrl
        } aluOp;

endpackage

//--- list.f
isaPkg.sv
pipePkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
cpuTop.sv
tbCpu.sv

//--- memoryStage.sv
`timescale 1ns/1ns

module memoryStage
        import pipePkg::*;
#(
        parameter int dmemDepth = 64
) (
        input  logic        clk,
        input  logic        rstN,
        input  exMem        memIn,
        output logic        branchTaken,
        output logic [31:0] branchTarget,
        output wbBus        wb
);

        localparam int dmemAw = $clog2(dmemDepth);

        // Word data memory, no reset
        logic [31:0] dmem [dmemDepth];

        logic [dmemAw-1:0] memIdx;
        logic [31:0]       memData;
        memWb              memWbReg;

        assign memIdx = memIn.aluResult[dmemAw+1:2];

        // Store only for a valid sw
        always_ff @(posedge clk) begin
                if (memIn.valid && memIn.memWrite) begin
                        dmem[memIdx] <= memIn.storeData;
                end
        end

        // Combinational load
        assign memData = memIn.memRead ? dmem[memIdx] : '0;

        // Branch resolves here, PC loads at end of this cycle
        assign branchTaken  = memIn.valid && memIn.branch && memIn.zero;
        assign branchTarget = memIn.branchTarget;

        // MEM/WB register
        always_ff @(posedge clk or negedge rstN) begin
                if (!rstN) begin
                        memWbReg.valid <= 1'b0;
                end else begin
                        memWbReg.valid     <= memIn.valid;
                        memWbReg.regWrite  <= memIn.regWrite;
                        memWbReg.memToReg  <= memIn.memToReg;
                        memWbReg.memData   <= memData;
                        memWbReg.aluResult <= memIn.aluResult;
                        memWbReg.writeReg  <= memIn.writeReg;
                end
        end

        // Writeback select, qualified by valid
        assign wb.regWrite = memWbReg.valid && memWbReg.regWrite;
        assign wb.writeReg = memWbReg.writeReg;
        assign wb.wbData   = memWbReg.memToReg ? memWbReg.memData : memWbReg.aluResult;

        // Base plus offset from execute lands on a word
        memAligned: assert property (@(posedge clk) disable iff (!rstN)
                memIn.valid && (memIn.memRead || memIn.memWrite) |-> memIn.aluResult[1:0] == 2'b00);

endmodule

//--- pipePkg.sv
package pipePkg;

        import isaPkg::*;

        ////////////////////////////////////////////////////////////////////////////
        // Pipeline registers
        ////////////////////////////////////////////////////////////////////////////

        typedef struct packed {
                logic        valid;
                logic [31:0] pcPlus4;
                instrWord    instr;
        } ifId;

        // Decoded controls plus operands
        typedef struct packed {
                logic        valid;
                logic        regWrite;
                logic        memToReg;
                logic        memWrite;
                logic        memRead;
                logic        branch;
                logic        aluSrc;
                logic        shiftOp;
                aluOp        alu;
                logic [31:0] rsData;
                logic [31:0] rtData;
                logic [31:0] imm;
                logic [4:0]  shamt;
                logic [31:0] pcPlus4;
                logic [4:0]  writeReg;
        } idEx;

        typedef struct packed {
                logic        valid;
                logic        regWrite;
                logic        memToReg;
                logic        memWrite;
                logic        memRead;
                logic        branch;
                logic        zero;
                logic [31:0] aluResult;
                logic [31:0] storeData;
                logic [31:0] branchTarget;
                logic [4:0]  writeReg;
        } exMem;

        typedef struct packed {
                logic        valid;
                logic        regWrite;
                logic        memToReg;
                logic [31:0] memData;
                logic [31:0] aluResult;
                logic [4:0]  writeReg;
        } memWb;

        // Writeback result, also the register file write
        typedef struct packed {
                logic        regWrite;
                logic [4:0]  writeReg;
                logic [31:0] wbData;
        } wbBus;

        // Program load, addr is a word index
        typedef struct packed {
                logic        en;
                logic [15:0] addr;
                logic [31:0] data;
        } progLoad;

endpackage

//--- runSim.sh
#!/usr/bin/env bash
# Build and run with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tbCpu -f list.f -o simCpu &&
./obj_dir/simCpu | tee /dev/stderr | grep -qx "Test passed" &&
echo "simulation ok" ||
{ echo "simulation FAILED"; exit 1; }

//--- tbCpu.sv
`timescale 1ns/1ns

module tbCpu
        import pipePkg::*;
();

        localparam int clkPeriod   = 20;
        localparam int resetCycles = 16;
        localparam int driveDelay  = 2;
        localparam int drainCycles = 20;
        localparam int seed        = 45666;
        localparam int patAw       = 8;
        localparam int patDepth    = 1 << patAw;

        logic        clk;
        logic        rstN;
        progLoad     load;
        logic [31:0] pc;
        wbBus        wb;

        // Image of cpuPatterns.txt
        logic [31:0] pat [patDepth];

        int wordCount;
        int expCount;
        int expIdx;
        int cycleCount;
        int cycleLimit;
        int testChecks;
        int testErrors;
        int testsRun;
        int testsFailed;
        int extraCount;
        int errors;

        cpuTop dut (
                .clk  (clk),
                .rstN (rstN),
                .load (load),
                .pc   (pc),
                .wb   (wb)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #(clkPeriod / 2) clk = ~clk;
                end
        end

        ////////////////////////////////////////////////////////////////////////////
        // Helpers
        ////////////////////////////////////////////////////////////////////////////

        function automatic logic [31:0] patternWord(input int idx);
                return pat[idx[patAw-1:0]];
        endfunction

        function automatic string testName(input int test);
                case (test)
                        0: return "program load, PC held at zero";
                        1: return "R-type arithmetic and logic";
                        2: return "immediate extension";
                        3: return "shifts by shamt";
                        4: return "store and load round trip";
                        5: return "taken and untaken beq";
                        6: return "register zero";
                        default: return "unnamed";
                endcase
        endfunction

        // Inputs change 2 ns after the rising edge
        task automatic nextDriveSlot();
                @(posedge clk);
                #driveDelay;
        endtask

        // PC frozen at zero while en is high
        task automatic checkPcHeld();
                if (pc !== 32'd0) begin
                        $display("** Error at %0t ns: pc = %h, expected %h",
                                 $time, pc, 32'd0);
                        testErrors++;
                end
                testChecks++;
        endtask

        // One word per cycle, random idle gaps with en still high
        task automatic loadProgram();
                int idle;
                for (int i = 0; i < wordCount; i++) begin
                        load.en   = 1'b1;
                        load.addr = 16'(i);
                        load.data = patternWord(1 + i);
                        nextDriveSlot();
                        checkPcHeld();
                        idle = $urandom_range(3, 0);
                        // Same word rewritten, PC still frozen
                        for (int j = 0; j < idle; j++) begin
                                nextDriveSlot();
                                checkPcHeld();
                        end
                end
                load.en = 1'b0;
                closeTest(0);
        endtask

        task automatic closeTest(input int test);
                if (testErrors == 0) begin
                        $display("[%0d] %s: %0d checks ok", test, testName(test), testChecks);
                end else begin
                        $display("[%0d] %s: %0d checks, %0d mismatches",
                                 test, testName(test), testChecks, testErrors);
                        testsFailed++;
                end
                testsRun++;
                errors    += testErrors;
                testErrors = 0;
                testChecks = 0;
        endtask

        // Compare one writeback with the next expected triple
        task automatic checkWriteback();
                int          k;
                int          test;
                logic [4:0]  expReg;
                logic [31:0] expVal;
                if (expIdx >= expCount) begin
                        $display("Extra writeback at %0t ns to r%0d with %h",
                                 $time, wb.writeReg, wb.wbData);
                        extraCount++;
                        errors++;
                end else begin
                        k      = wordCount + 2 + 3 * expIdx;
                        test   = int'(patternWord(k));
                        expReg = 5'(patternWord(k + 1));
                        expVal = patternWord(k + 2);
                        if (wb.writeReg !== expReg) begin
                                $display("** Error at %0t ns: wb.writeReg = %0d, expected %0d",
                                         $time, wb.writeReg, expReg);
                                testErrors++;
                        end
                        if (wb.wbData !== expVal) begin
                                $display("** Error at %0t ns: wb.wbData = %h, expected %h",
                                         $time, wb.wbData, expVal);
                                testErrors++;
                        end
                        testChecks++;
                        expIdx++;
                        // Test ends at a change of test number
                        if (expIdx == expCount || int'(patternWord(k + 3)) != test) begin
                                closeTest(test);
                        end
                end
        endtask

        ////////////////////////////////////////////////////////////////////////////
        // Checking and run control
        ////////////////////////////////////////////////////////////////////////////

        // wb settles after the rising edge, sample mid-cycle
        always @(negedge clk) begin
                if (rstN && wb.regWrite) begin
                        checkWriteback();
                end
        end

        initial begin
                cycleCount = 0;
                while (cycleCount <= cycleLimit) begin
                        @(posedge clk);
                        cycleCount++;
                end
                $display("Timeout after %0d cycles, %0d of %0d writebacks seen, %0d missing",
                         cycleCount, expIdx, expCount, expCount - expIdx);
                $display("Test failed");
                $finish;
        end

        initial begin
                rstN = 1'b0;
                load = '0;
                void'($urandom(seed));
                $readmemh("cpuPatterns.txt", pat);
                wordCount = int'(pat[0]);
                expCount  = int'(patternWord(wordCount + 1));
                // Worst-case load is four cycles per word
                cycleLimit = (resetCycles + 4 * wordCount) * 4 + wordCount * 4 + 50;

                repeat (resetCycles) @(posedge clk);
                #driveDelay;
                rstN = 1'b1;
                // en rises with reset release, so nothing is fetched before the load
                loadProgram();

                while (expIdx < expCount) begin
                        nextDriveSlot();
                end
                // Halt loop writes nothing, any wb now is extra
                repeat (drainCycles) nextDriveSlot();

                if (expCount == 0) begin
                        $display("No expected writebacks found in cpuPatterns.txt");
                end
                $display("Done: %0d tests, %0d failed, %0d/%0d writebacks, %0d extra, %0d errors",
                         testsRun, testsFailed, expIdx, expCount, extraCount, errors);
                if (errors == 0 && expCount > 0) begin
                        $display("Test passed");
                end else begin
                        $display("Test failed");
                end
                $finish;
        end

endmodule
